//--- rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

  // control-transfer opcodes only, the unit sees nothing else
  typedef enum logic [6:0] {
    br_opcode   = 7'b1100011,
    jalr_opcode = 7'b1100111,
    jal_opcode  = 7'b1101111
  } opcode_t;

  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } br_funct3_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // B-immediate bits are scattered around rs1/rs2
  typedef struct packed {
    logic        imm12;
    logic [5:0]  imm10_5;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [3:0]  imm4_1;
    logic        imm11;
    logic [6:0]  opcode;
  } b_fmt_t;

  typedef struct packed {
    logic        imm20;
    logic [9:0]  imm10_1;
    logic        imm11;
    logic [7:0]  imm19_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } j_fmt_t;

  typedef union packed {
    i_fmt_t i_fmt;
    b_fmt_t b_fmt;
    j_fmt_t j_fmt;
  } instr_u;

endpackage

`default_nettype wire

//--- ooo_pkg.sv
`default_nettype none

package ooo_pkg;

  // data or address word
  typedef logic [31:0] word_t;

  // what the station keeps instead of the raw opcode
  typedef enum logic [1:0] {
    k_jal,
    k_jalr,
    k_cond
  } br_kind_t;

endpackage

`default_nettype wire

//--- rs_issue_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rs_issue_if
  import rv32i_pkg::*;
  import ooo_pkg::*;
#(
  parameter int ROB_DEPTH = 3
) ();

  logic                 write;
  br_kind_t             kind;
  br_funct3_t           funct3;
  word_t                imm;
  word_t                pc;
  logic [ROB_DEPTH-1:0] target_rob;

  logic                 rs1_ready;
  word_t                rs1_v;
  logic [ROB_DEPTH-1:0] rs1_rob;
  logic                 rs2_ready;
  word_t                rs2_v;
  logic [ROB_DEPTH-1:0] rs2_rob;

  logic                 full;

  modport decode (
    output write, kind, funct3, imm, pc, target_rob,
    output rs1_ready, rs1_v, rs1_rob, rs2_ready, rs2_v, rs2_rob,
    input  full
  );

  modport rs (
    input  write, kind, funct3, imm, pc, target_rob,
    input  rs1_ready, rs1_v, rs1_rob, rs2_ready, rs2_v, rs2_rob,
    output full
  );

endinterface

`default_nettype wire

//--- br_exec_if.sv
`timescale 1ns/1ps
`default_nettype none

interface br_exec_if
  import rv32i_pkg::*;
  import ooo_pkg::*;
#(
  parameter int ROB_DEPTH = 3
) ();

  // valid is a level; the resolver always takes the entry
  logic                 valid;
  br_kind_t             kind;
  br_funct3_t           funct3;
  word_t                pc;
  word_t                imm;
  word_t                rs1_v;
  word_t                rs2_v;
  logic [ROB_DEPTH-1:0] target_rob;

  modport rs (
    output valid, kind, funct3, pc, imm, rs1_v, rs2_v, target_rob
  );

  modport exec (
    input valid, kind, funct3, pc, imm, rs1_v, rs2_v, target_rob
  );

endinterface

`default_nettype wire

//--- branch_issue_decode.sv
`timescale 1ns/1ps
`default_nettype none

module branch_issue_decode
  import rv32i_pkg::*;
  import ooo_pkg::*;
#(
  parameter int ROB_DEPTH = 3
) (
  input  wire logic                 issue,
  input  wire instr_u               issue_instr,
  input  wire word_t                issue_pc,
  input  wire logic [ROB_DEPTH-1:0] issue_target_rob,

  input  wire logic                 rs1_regfile_ready,
  input  wire logic                 rs2_regfile_ready,
  input  wire word_t                rs1_regfile_v,
  input  wire word_t                rs2_regfile_v,
  input  wire logic [ROB_DEPTH-1:0] rs1_regfile_rob,
  input  wire logic [ROB_DEPTH-1:0] rs2_regfile_rob,

  input  wire logic                 rs1_rob_ready,
  input  wire logic                 rs2_rob_ready,
  input  wire word_t                rs1_rob_v,
  input  wire word_t                rs2_rob_v,

  rs_issue_if.decode                iss
);

  logic [6:0] opc;

  // opcode sits in the same bits for every format
  assign opc = issue_instr.i_fmt.opcode;

  always_comb begin
    iss.write      = issue;
    iss.pc         = issue_pc;
    iss.target_rob = issue_target_rob;
    iss.funct3     = br_funct3_t'(issue_instr.b_fmt.funct3);
    iss.rs1_rob    = rs1_regfile_rob;
    iss.rs2_rob    = rs2_regfile_rob;

    // regfile first, then rob, else wait on the tag
    iss.rs1_ready  = rs1_regfile_ready | rs1_rob_ready;
    iss.rs1_v      = rs1_regfile_ready ? rs1_regfile_v : rs1_rob_v;
    iss.rs2_ready  = rs2_regfile_ready | rs2_rob_ready;
    iss.rs2_v      = rs2_regfile_ready ? rs2_regfile_v : rs2_rob_v;

    iss.kind       = k_cond;
    iss.imm        = '0;
    case (opc)
      jal_opcode: begin
        iss.kind      = k_jal;
        iss.imm       = {{11{issue_instr.j_fmt.imm20}}, issue_instr.j_fmt.imm20,
                         issue_instr.j_fmt.imm19_12, issue_instr.j_fmt.imm11,
                         issue_instr.j_fmt.imm10_1, 1'b0};
        // no register operand at all
        iss.rs1_ready = 1'b1;
        iss.rs2_ready = 1'b1;
      end
      jalr_opcode: begin
        iss.kind      = k_jalr;
        iss.imm       = {{20{issue_instr.i_fmt.imm[11]}}, issue_instr.i_fmt.imm};
        iss.rs2_ready = 1'b1;
      end
      br_opcode: begin
        iss.kind      = k_cond;
        iss.imm       = {{19{issue_instr.b_fmt.imm12}}, issue_instr.b_fmt.imm12,
                         issue_instr.b_fmt.imm11, issue_instr.b_fmt.imm10_5,
                         issue_instr.b_fmt.imm4_1, 1'b0};
      end
      default: begin
        iss.kind      = k_cond;
      end
    endcase
  end

  // issue stage must only route control-transfer instructions here
  a_issue_opcode: assert final (!issue || opc == jal_opcode || opc == jalr_opcode ||
                                opc == br_opcode)
    else $error("branch unit issued with non-branch opcode %b", opc);

endmodule

`default_nettype wire

//--- branch_rs.sv
`timescale 1ns/1ps
`default_nettype none

module branch_rs
  import rv32i_pkg::*;
  import ooo_pkg::*;
#(
  parameter int RS_DEPTH  = 3,
  parameter int ROB_DEPTH = 3,
  parameter int CDB_SIZE  = 3
) (
  input  wire logic                 clk,
  input  wire logic                 rst,

  rs_issue_if.rs                    iss,

  input  wire logic                 cdb_valid [CDB_SIZE],
  input  wire logic [ROB_DEPTH-1:0] cdb_rob   [CDB_SIZE],
  input  wire word_t                cdb_rd_v  [CDB_SIZE],

  br_exec_if.rs                     ex
);

  localparam int NUM = 2 ** RS_DEPTH;

  // control state
  logic                 busy_q     [NUM];
  logic                 rs1_rdy_q  [NUM];
  logic                 rs2_rdy_q  [NUM];
  logic [RS_DEPTH-1:0]  rr_ptr_q;

  // payload
  br_kind_t             kind_q     [NUM];
  br_funct3_t           funct3_q   [NUM];
  word_t                imm_q      [NUM];
  word_t                pc_q       [NUM];
  word_t                rs1_v_q    [NUM];
  word_t                rs2_v_q    [NUM];
  logic [ROB_DEPTH-1:0] rs1_rob_q  [NUM];
  logic [ROB_DEPTH-1:0] rs2_rob_q  [NUM];
  logic [ROB_DEPTH-1:0] tgt_q      [NUM];

  logic                 rs1_hit    [NUM];
  logic                 rs2_hit    [NUM];
  word_t                rs1_cdb    [NUM];
  word_t                rs2_cdb    [NUM];
  logic                 new_rs1_hit;
  logic                 new_rs2_hit;
  word_t                new_rs1_cdb;
  word_t                new_rs2_cdb;
  logic                 cdb_dup;

  logic [RS_DEPTH-1:0]  alloc_idx;
  logic [RS_DEPTH-1:0]  sel_idx;
  logic                 sel_valid;

  // cdb tag match per stored operand and for the incoming entry
  always_comb begin
    new_rs1_hit = 1'b0;
    new_rs2_hit = 1'b0;
    new_rs1_cdb = '0;
    new_rs2_cdb = '0;
    for (int i = 0; i < NUM; i++) begin
      rs1_hit[i] = 1'b0;
      rs2_hit[i] = 1'b0;
      rs1_cdb[i] = '0;
      rs2_cdb[i] = '0;
      for (int j = 0; j < CDB_SIZE; j++) begin
        if (cdb_valid[j] && cdb_rob[j] == rs1_rob_q[i]) begin
          rs1_hit[i] = 1'b1;
          rs1_cdb[i] = cdb_rd_v[j];
        end
        if (cdb_valid[j] && cdb_rob[j] == rs2_rob_q[i]) begin
          rs2_hit[i] = 1'b1;
          rs2_cdb[i] = cdb_rd_v[j];
        end
      end
    end
    for (int j = 0; j < CDB_SIZE; j++) begin
      if (cdb_valid[j] && cdb_rob[j] == iss.rs1_rob) begin
        new_rs1_hit = 1'b1;
        new_rs1_cdb = cdb_rd_v[j];
      end
      if (cdb_valid[j] && cdb_rob[j] == iss.rs2_rob) begin
        new_rs2_hit = 1'b1;
        new_rs2_cdb = cdb_rd_v[j];
      end
    end
  end

  // lowest free slot, full when none
  always_comb begin
    alloc_idx = '0;
    iss.full  = 1'b1;
    for (int i = NUM - 1; i >= 0; i--) begin
      if (!busy_q[i]) begin
        alloc_idx = RS_DEPTH'(i);
        iss.full  = 1'b0;
      end
    end
  end

  // round robin starting at rr_ptr_q, wraps on RS_DEPTH bits
  always_comb begin
    logic [RS_DEPTH-1:0] idx;
    sel_valid = 1'b0;
    sel_idx   = '0;
    for (int i = 0; i < NUM; i++) begin
      idx = rr_ptr_q + RS_DEPTH'(i);
      if (!sel_valid && busy_q[idx] && rs1_rdy_q[idx] && rs2_rdy_q[idx]) begin
        sel_valid = 1'b1;
        sel_idx   = idx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rr_ptr_q <= '0;
      for (int i = 0; i < NUM; i++) begin
        busy_q[i]    <= 1'b0;
        rs1_rdy_q[i] <= 1'b0;
        rs2_rdy_q[i] <= 1'b0;
      end
    end else begin
      // wake-up
      for (int i = 0; i < NUM; i++) begin
        if (busy_q[i] && !rs1_rdy_q[i] && rs1_hit[i]) begin
          rs1_rdy_q[i] <= 1'b1;
        end
        if (busy_q[i] && !rs2_rdy_q[i] && rs2_hit[i]) begin
          rs2_rdy_q[i] <= 1'b1;
        end
      end
      // resolved this cycle, free at the edge
      if (sel_valid) begin
        busy_q[sel_idx] <= 1'b0;
        rr_ptr_q        <= sel_idx + 1'b1;
      end
      if (iss.write) begin
        busy_q[alloc_idx]    <= 1'b1;
        rs1_rdy_q[alloc_idx] <= iss.rs1_ready | new_rs1_hit;
        rs2_rdy_q[alloc_idx] <= iss.rs2_ready | new_rs2_hit;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM; i++) begin
      if (busy_q[i] && !rs1_rdy_q[i] && rs1_hit[i]) begin
        rs1_v_q[i] <= rs1_cdb[i];
      end
      if (busy_q[i] && !rs2_rdy_q[i] && rs2_hit[i]) begin
        rs2_v_q[i] <= rs2_cdb[i];
      end
    end
    if (iss.write) begin
      kind_q[alloc_idx]    <= iss.kind;
      funct3_q[alloc_idx]  <= iss.funct3;
      imm_q[alloc_idx]     <= iss.imm;
      pc_q[alloc_idx]      <= iss.pc;
      rs1_rob_q[alloc_idx] <= iss.rs1_rob;
      rs2_rob_q[alloc_idx] <= iss.rs2_rob;
      tgt_q[alloc_idx]     <= iss.target_rob;
      rs1_v_q[alloc_idx]   <= iss.rs1_ready ? iss.rs1_v : new_rs1_cdb;
      rs2_v_q[alloc_idx]   <= iss.rs2_ready ? iss.rs2_v : new_rs2_cdb;
    end
  end

  always_comb begin
    ex.valid      = sel_valid;
    ex.kind       = kind_q[sel_idx];
    ex.funct3     = funct3_q[sel_idx];
    ex.pc         = pc_q[sel_idx];
    ex.imm        = imm_q[sel_idx];
    ex.rs1_v      = rs1_v_q[sel_idx];
    ex.rs2_v      = rs2_v_q[sel_idx];
    ex.target_rob = tgt_q[sel_idx];
  end

  // two cdb ports never broadcast the same rob tag
  always_comb begin
    cdb_dup = 1'b0;
    for (int j = 0; j < CDB_SIZE; j++) begin
      for (int k = j + 1; k < CDB_SIZE; k++) begin
        if (cdb_valid[j] && cdb_valid[k] && cdb_rob[j] == cdb_rob[k]) begin
          cdb_dup = 1'b1;
        end
      end
    end
  end

  a_no_write_full: assert property (@(posedge clk) disable iff (rst) iss.write |-> !iss.full)
    else $error("branch station written while full");

  a_sel_busy: assert property (@(posedge clk) disable iff (rst) ex.valid |-> busy_q[sel_idx])
    else $error("selected station slot %0d is not occupied", sel_idx);

  a_cdb_unique: assert property (@(posedge clk) disable iff (rst) !cdb_dup)
    else $error("same rob tag on more than one cdb port");

endmodule

`default_nettype wire

//--- branch_exec.sv
`timescale 1ns/1ps
`default_nettype none

module branch_exec
  import rv32i_pkg::*;
  import ooo_pkg::*;
#(
  parameter int ROB_DEPTH = 3
) (
  br_exec_if.exec              ex,

  output logic                 cdb_branch_valid,
  output word_t                cdb_branch_v,
  output logic [ROB_DEPTH-1:0] cdb_branch_rob,
  output logic                 branch_take,
  output word_t                branch_pc
);

  logic  cond_take;
  word_t pc_imm;
  word_t link;

  assign pc_imm = ex.pc + ex.imm;
  assign link   = ex.pc + 32'd4;

  always_comb begin
    case (ex.funct3)
      beq:     cond_take = ex.rs1_v == ex.rs2_v;
      bne:     cond_take = ex.rs1_v != ex.rs2_v;
      blt:     cond_take = $signed(ex.rs1_v) < $signed(ex.rs2_v);
      bge:     cond_take = $signed(ex.rs1_v) >= $signed(ex.rs2_v);
      bltu:    cond_take = ex.rs1_v < ex.rs2_v;
      bgeu:    cond_take = ex.rs1_v >= ex.rs2_v;
      default: cond_take = 1'b0;
    endcase
  end

  always_comb begin
    cdb_branch_valid = 1'b0;
    cdb_branch_v     = '0;
    cdb_branch_rob   = '0;
    branch_take      = 1'b0;
    branch_pc        = '0;
    if (ex.valid) begin
      cdb_branch_valid = 1'b1;
      cdb_branch_rob   = ex.target_rob;
      case (ex.kind)
        k_jal: begin
          branch_take  = 1'b1;
          branch_pc    = pc_imm;
          cdb_branch_v = link;
        end
        k_jalr: begin
          branch_take  = 1'b1;
          // jalr drops bit 0 of the sum
          branch_pc    = (ex.rs1_v + ex.imm) & ~32'd1;
          cdb_branch_v = link;
        end
        default: begin
          branch_take  = cond_take;
          branch_pc    = cond_take ? pc_imm : '0;
        end
      endcase
    end
  end

  // relies on aligned pcs coming in from fetch
  a_target_align: assert final (!branch_take || !branch_pc[0])
    else $error("taken branch target %h is not 2-byte aligned", branch_pc);

endmodule

`default_nettype wire

//--- branch_top.sv
`timescale 1ns/1ps
`default_nettype none

module branch_top
  import rv32i_pkg::*;
  import ooo_pkg::*;
#(
  parameter int RS_DEPTH  = 3,
  parameter int ROB_DEPTH = 3,
  parameter int CDB_SIZE  = 3
) (
  input  wire logic                 clk,
  input  wire logic                 rst,

  input  wire logic                 issue,
  input  wire instr_u               issue_instr,
  input  wire word_t                issue_pc,
  input  wire logic [ROB_DEPTH-1:0] issue_target_rob,

  input  wire logic                 rs1_regfile_ready,
  input  wire logic                 rs2_regfile_ready,
  input  wire word_t                rs1_regfile_v,
  input  wire word_t                rs2_regfile_v,
  input  wire logic [ROB_DEPTH-1:0] rs1_regfile_rob,
  input  wire logic [ROB_DEPTH-1:0] rs2_regfile_rob,
  input  wire logic                 rs1_rob_ready,
  input  wire logic                 rs2_rob_ready,
  input  wire word_t                rs1_rob_v,
  input  wire word_t                rs2_rob_v,

  input  wire logic                 cdb_valid [CDB_SIZE],
  input  wire logic [ROB_DEPTH-1:0] cdb_rob   [CDB_SIZE],
  input  wire word_t                cdb_rd_v  [CDB_SIZE],

  output logic                      rs_full,

  output logic                      cdb_branch_valid,
  output word_t                     cdb_branch_v,
  output logic [ROB_DEPTH-1:0]      cdb_branch_rob,
  output logic                      branch_take,
  output word_t                     branch_pc
);

  rs_issue_if #(.ROB_DEPTH(ROB_DEPTH)) iss_if ();
  br_exec_if  #(.ROB_DEPTH(ROB_DEPTH)) ex_if ();

  assign rs_full = iss_if.full;

  branch_issue_decode #(
    .ROB_DEPTH (ROB_DEPTH)
  ) decode0 (
    .issue             (issue),
    .issue_instr       (issue_instr),
    .issue_pc          (issue_pc),
    .issue_target_rob  (issue_target_rob),
    .rs1_regfile_ready (rs1_regfile_ready),
    .rs2_regfile_ready (rs2_regfile_ready),
    .rs1_regfile_v     (rs1_regfile_v),
    .rs2_regfile_v     (rs2_regfile_v),
    .rs1_regfile_rob   (rs1_regfile_rob),
    .rs2_regfile_rob   (rs2_regfile_rob),
    .rs1_rob_ready     (rs1_rob_ready),
    .rs2_rob_ready     (rs2_rob_ready),
    .rs1_rob_v         (rs1_rob_v),
    .rs2_rob_v         (rs2_rob_v),
    .iss               (iss_if.decode)
  );

  branch_rs #(
    .RS_DEPTH  (RS_DEPTH),
    .ROB_DEPTH (ROB_DEPTH),
    .CDB_SIZE  (CDB_SIZE)
  ) rs0 (
    .clk       (clk),
    .rst       (rst),
    .iss       (iss_if.rs),
    .cdb_valid (cdb_valid),
    .cdb_rob   (cdb_rob),
    .cdb_rd_v  (cdb_rd_v),
    .ex        (ex_if.rs)
  );

  branch_exec #(
    .ROB_DEPTH (ROB_DEPTH)
  ) exec0 (
    .ex               (ex_if.exec),
    .cdb_branch_valid (cdb_branch_valid),
    .cdb_branch_v     (cdb_branch_v),
    .cdb_branch_rob   (cdb_branch_rob),
    .branch_take      (branch_take),
    .branch_pc        (branch_pc)
  );

endmodule

`default_nettype wire

//--- tb_branch_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_branch_top
  import rv32i_pkg::*;
  import ooo_pkg::*;
();

  localparam int DRAIN_LIMIT = 64;
  localparam int WAIT_LIMIT  = 16;
  localparam int WATCHDOG    = 5000;
  localparam int PENDING     = 32'h3fff_ffff;
  localparam int SRC_WAIT    = 0;
  localparam int SRC_RF      = 1;
  localparam int SRC_ROB     = 2;

  logic       clk;
  logic       rst;
  logic       issue;
  instr_u     issue_instr;
  word_t      issue_pc;
  logic [2:0] issue_target_rob;
  logic       rs1_regfile_ready;
  logic       rs2_regfile_ready;
  word_t      rs1_regfile_v;
  word_t      rs2_regfile_v;
  logic [2:0] rs1_regfile_rob;
  logic [2:0] rs2_regfile_rob;
  logic       rs1_rob_ready;
  logic       rs2_rob_ready;
  word_t      rs1_rob_v;
  word_t      rs2_rob_v;
  logic       cdb_valid [3];
  logic [2:0] cdb_rob   [3];
  word_t      cdb_rd_v  [3];
  logic       rs_full;
  logic       cdb_branch_valid;
  word_t      cdb_branch_v;
  logic [2:0] cdb_branch_rob;
  logic       branch_take;
  word_t      branch_pc;

  int         seed = 46533;
  int         errors = 0;
  int         checks = 0;
  int         results = 0;
  int         cyc = 0;
  logic [2:0] next_tag = 3'd0;

  // expected state per rob tag
  logic       sb_valid [8];
  br_kind_t   sb_kind  [8];
  br_funct3_t sb_f3    [8];
  word_t      sb_pc    [8];
  word_t      sb_imm   [8];
  word_t      sb_op1   [8];
  word_t      sb_op2   [8];
  logic       sb_need1 [8];
  logic       sb_need2 [8];
  logic [2:0] sb_wait1 [8];
  logic [2:0] sb_wait2 [8];
  int         sb_min   [8];
  logic       sb_exact [8];

  branch_top dut0 (
    .clk (clk), .rst (rst), .issue (issue), .issue_instr (issue_instr),
    .issue_pc (issue_pc), .issue_target_rob (issue_target_rob),
    .rs1_regfile_ready (rs1_regfile_ready), .rs2_regfile_ready (rs2_regfile_ready),
    .rs1_regfile_v (rs1_regfile_v), .rs2_regfile_v (rs2_regfile_v),
    .rs1_regfile_rob (rs1_regfile_rob), .rs2_regfile_rob (rs2_regfile_rob),
    .rs1_rob_ready (rs1_rob_ready), .rs2_rob_ready (rs2_rob_ready),
    .rs1_rob_v (rs1_rob_v), .rs2_rob_v (rs2_rob_v),
    .cdb_valid (cdb_valid), .cdb_rob (cdb_rob), .cdb_rd_v (cdb_rd_v),
    .rs_full (rs_full), .cdb_branch_valid (cdb_branch_valid),
    .cdb_branch_v (cdb_branch_v), .cdb_branch_rob (cdb_branch_rob),
    .branch_take (branch_take), .branch_pc (branch_pc)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  function automatic word_t rnd();
    return $random(seed);
  endfunction

  function automatic word_t aligned_pc();
    word_t r;
    r = rnd();
    return {r[31:2], 2'b00};
  endfunction

  function automatic logic [2:0] take_tag();
    logic [2:0] t;
    t = next_tag;
    next_tag = next_tag + 3'd1;
    return t;
  endfunction

  function automatic br_funct3_t f3_of(input int k);
    case (k)
      0:       return beq;
      1:       return bne;
      2:       return blt;
      3:       return bge;
      4:       return bltu;
      default: return bgeu;
    endcase
  endfunction

  // ISA encodings of the three formats
  function automatic instr_u jal_word(input word_t imm);
    instr_u x;
    x = '0;
    x.j_fmt.imm20    = imm[20];
    x.j_fmt.imm19_12 = imm[19:12];
    x.j_fmt.imm11    = imm[11];
    x.j_fmt.imm10_1  = imm[10:1];
    x.j_fmt.rd       = 5'd1;
    x.j_fmt.opcode   = jal_opcode;
    return x;
  endfunction

  function automatic instr_u jalr_word(input word_t imm);
    word_t r;
    instr_u x;
    r = rnd();
    x = '0;
    x.i_fmt.imm    = imm[11:0];
    x.i_fmt.rs1    = r[4:0];
    x.i_fmt.rd     = 5'd1;
    x.i_fmt.opcode = jalr_opcode;
    return x;
  endfunction

  function automatic instr_u branch_word(input br_funct3_t f3, input word_t imm);
    word_t r;
    instr_u x;
    r = rnd();
    x = '0;
    x.b_fmt.imm12   = imm[12];
    x.b_fmt.imm11   = imm[11];
    x.b_fmt.imm10_5 = imm[10:5];
    x.b_fmt.imm4_1  = imm[4:1];
    x.b_fmt.rs1     = r[4:0];
    x.b_fmt.rs2     = r[9:5];
    x.b_fmt.funct3  = f3;
    x.b_fmt.opcode  = br_opcode;
    return x;
  endfunction

  // signed order is unsigned order with the sign bit flipped
  function automatic logic cond_taken(input br_funct3_t f3, input word_t a, input word_t b);
    word_t sa;
    word_t sb;
    sa = a ^ 32'h8000_0000;
    sb = b ^ 32'h8000_0000;
    case (f3)
      beq:     return a == b;
      bne:     return a != b;
      blt:     return sa < sb;
      bge:     return !(sa < sb);
      bltu:    return a < b;
      default: return !(a < b);
    endcase
  endfunction

  function automatic logic taken_for(input int t);
    return (sb_kind[t] == k_cond) ? cond_taken(sb_f3[t], sb_op1[t], sb_op2[t]) : 1'b1;
  endfunction

  function automatic word_t target_for(input int t);
    if (sb_kind[t] == k_jalr) begin
      return (sb_op1[t] + sb_imm[t]) & 32'hffff_fffe;
    end
    return taken_for(t) ? sb_pc[t] + sb_imm[t] : 32'd0;
  endfunction

  function automatic word_t link_for(input int t);
    return (sb_kind[t] == k_cond) ? 32'd0 : sb_pc[t] + 32'd4;
  endfunction

  function automatic int pending_count();
    int n;
    n = 0;
    for (int t = 0; t < 8; t++) begin
      if (sb_valid[t]) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("ERROR at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
    end
  endtask

  // equal values and sign edges show up often
  task automatic pick_operands(output word_t a, output word_t b);
    word_t edges [5];
    int mode;
    edges = '{32'h0000_0000, 32'h0000_0001, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
    mode = $unsigned($random(seed)) % 4;
    a = rnd();
    b = rnd();
    if (mode == 1) begin
      b = a;
    end else if (mode == 2) begin
      a = edges[$unsigned($random(seed)) % 5];
      b = edges[$unsigned($random(seed)) % 5];
    end else if (mode == 3) begin
      b = a + (b[0] ? 32'd1 : 32'hffff_ffff);
    end
  endtask

  task automatic clear_cdb();
    for (int j = 0; j < 3; j++) begin
      cdb_valid[j] = 1'b0;
      cdb_rob[j]   = '0;
      cdb_rd_v[j]  = '0;
    end
  endtask

  task automatic init_inputs();
    rst               = 1'b1;
    issue             = 1'b0;
    issue_instr       = '0;
    issue_pc          = '0;
    issue_target_rob  = '0;
    rs1_regfile_ready = 1'b0;
    rs2_regfile_ready = 1'b0;
    rs1_regfile_v     = '0;
    rs2_regfile_v     = '0;
    rs1_regfile_rob   = '0;
    rs2_regfile_rob   = '0;
    rs1_rob_ready     = 1'b0;
    rs2_rob_ready     = 1'b0;
    rs1_rob_v         = '0;
    rs2_rob_v         = '0;
    clear_cdb();
    for (int t = 0; t < 8; t++) begin
      sb_valid[t] = 1'b0;
    end
  endtask

  // one issue on this falling edge, strobe dropped on the next
  task automatic issue_entry(input instr_u instr, input br_kind_t kind, input br_funct3_t f3,
                             input word_t imm, input word_t pc, input logic [2:0] tag,
                             input int src1, input word_t a, input logic [2:0] t1,
                             input int src2, input word_t b, input logic [2:0] t2);
    check("rs_full", 1'b0, rs_full);
    issue             = 1'b1;
    issue_instr       = instr;
    issue_pc          = pc;
    issue_target_rob  = tag;
    rs1_regfile_ready = (src1 == SRC_RF);
    rs1_rob_ready     = (src1 == SRC_ROB);
    rs1_regfile_v     = (src1 == SRC_RF) ? a : rnd();
    rs1_rob_v         = (src1 == SRC_ROB) ? a : rnd();
    rs1_regfile_rob   = t1;
    rs2_regfile_ready = (src2 == SRC_RF);
    rs2_rob_ready     = (src2 == SRC_ROB);
    rs2_regfile_v     = (src2 == SRC_RF) ? b : rnd();
    rs2_rob_v         = (src2 == SRC_ROB) ? b : rnd();
    rs2_regfile_rob   = t2;
    sb_valid[tag] = 1'b1;
    sb_kind[tag]  = kind;
    sb_f3[tag]    = f3;
    sb_pc[tag]    = pc;
    sb_imm[tag]   = imm;
    sb_op1[tag]   = a;
    sb_op2[tag]   = b;
    sb_wait1[tag] = t1;
    sb_wait2[tag] = t2;
    // jal needs no register, jalr only rs1
    sb_need1[tag] = (kind != k_jal) && (src1 == SRC_WAIT);
    sb_need2[tag] = (kind == k_cond) && (src2 == SRC_WAIT);
    sb_exact[tag] = !sb_need1[tag] && !sb_need2[tag];
    sb_min[tag]   = sb_exact[tag] ? cyc + 1 : PENDING;
    @(negedge clk);
    issue             = 1'b0;
    rs1_regfile_ready = 1'b0;
    rs1_rob_ready     = 1'b0;
    rs2_regfile_ready = 1'b0;
    rs2_rob_ready     = 1'b0;
  endtask

  task automatic drive_cdb(input int port, input logic [2:0] tag, input word_t value);
    logic woke;
    cdb_valid[port] = 1'b1;
    cdb_rob[port]   = tag;
    cdb_rd_v[port]  = value;
    for (int t = 0; t < 8; t++) begin
      woke = 1'b0;
      if (sb_valid[t] && sb_need1[t] && sb_wait1[t] == tag) begin
        sb_op1[t]   = value;
        sb_need1[t] = 1'b0;
        woke        = 1'b1;
      end
      if (sb_valid[t] && sb_need2[t] && sb_wait2[t] == tag) begin
        sb_op2[t]   = value;
        sb_need2[t] = 1'b0;
        woke        = 1'b1;
      end
      if (woke && !sb_need1[t] && !sb_need2[t]) begin
        sb_min[t] = cyc + 1;
      end
    end
  endtask

  task automatic wait_drain(input string what);
    int n;
    n = 0;
    while (pending_count() != 0 && n < DRAIN_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (pending_count() != 0) begin
      errors++;
      $display("timeout at %0t ns: %s still had %0d results outstanding", $time, what,
               pending_count());
      for (int t = 0; t < 8; t++) begin
        sb_valid[t] = 1'b0;
      end
    end
  endtask

  task automatic check_idle();
    check("rs_full", 1'b0, rs_full);
    check("cdb_branch_valid", 1'b0, cdb_branch_valid);
    check("branch_take", 1'b0, branch_take);
  endtask

  task automatic finish_run();
    $display("checks: %0d, results: %0d, errors: %0d", checks, results, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  // compare each result with the scoreboard entry for its tag
  always @(posedge clk) begin : monitor
    logic [2:0] t;
    t = cdb_branch_rob;
    if (!rst && cdb_branch_valid === 1'b1) begin
      results++;
      assert (sb_valid[t]) else begin
        errors++;
        $display("at %0t ns: result for rob tag %0d with no branch waiting on it", $time, t);
      end
      if (sb_valid[t]) begin
        check("branch_take", taken_for(t), branch_take);
        check("branch_pc", target_for(t), branch_pc);
        check("cdb_branch_v", link_for(t), cdb_branch_v);
        if (sb_exact[t]) begin
          check("result cycle", sb_min[t], cyc);
        end else begin
          assert (cyc >= sb_min[t]) else begin
            errors++;
            $display("at %0t ns: tag %0d resolved before its operands were broadcast",
                     $time, t);
          end
        end
        sb_valid[t] = 1'b0;
      end
    end
  end

  a_idle_outputs: assert property (@(posedge clk) disable iff (rst)
      !cdb_branch_valid |-> (!branch_take && branch_pc == '0 && cdb_branch_v == '0 &&
                             cdb_branch_rob == '0))
    else begin
      errors++;
      $display("at %0t ns: result outputs not zero while cdb_branch_valid is low", $time);
    end

  initial begin : watchdog
    repeat (WATCHDOG) @(posedge clk);
    errors++;
    $display("timeout: run did not finish within %0d cycles", WATCHDOG);
    finish_run();
  end

  initial begin : stimulus
    int i;
    int k;
    int p;
    int n;
    word_t a;
    word_t b;
    word_t r;
    word_t imm;
    br_funct3_t f3;

    init_inputs();
    for (i = 0; i < 8; i++) begin
      @(negedge clk);
      check_idle();
    end
    rst = 1'b0;
    @(negedge clk);
    check_idle();

    // jumps on an empty station
    for (k = 0; k < 4; k++) begin
      r = rnd();
      imm = {{11{r[20]}}, r[20:1], 1'b0};
      issue_entry(jal_word(imm), k_jal, beq, imm, aligned_pc(), take_tag(),
                  SRC_WAIT, '0, 3'd0, SRC_WAIT, '0, 3'd0);
      r = rnd();
      imm = {{20{r[11]}}, r[11:0]};
      issue_entry(jalr_word(imm), k_jalr, beq, imm, aligned_pc(), take_tag(),
                  SRC_RF, rnd(), 3'd0, SRC_WAIT, '0, 3'd0);
      r = rnd();
      imm = {{20{r[11]}}, r[11:0]};
      issue_entry(jalr_word(imm), k_jalr, beq, imm, aligned_pc(), take_tag(),
                  SRC_ROB, rnd(), 3'd0, SRC_WAIT, '0, 3'd0);
    end
    wait_drain("jal and jalr");

    // all six compares, operands ready at issue
    for (k = 0; k < 6; k++) begin
      for (i = 0; i < 6; i++) begin
        pick_operands(a, b);
        r = rnd();
        imm = {{19{r[12]}}, r[12:1], 1'b0};
        issue_entry(branch_word(f3_of(k), imm), k_cond, f3_of(k), imm, aligned_pc(),
                    take_tag(), (i % 2 == 0) ? SRC_RF : SRC_ROB, a, 3'd0,
                    (i % 3 == 0) ? SRC_ROB : SRC_RF, b, 3'd0);
      end
    end
    wait_drain("conditional branches");

    // wake-up through each cdb port
    for (p = 0; p < 3; p++) begin
      pick_operands(a, b);
      f3 = f3_of($unsigned($random(seed)) % 6);
      r = rnd();
      imm = {{19{r[12]}}, r[12:1], 1'b0};
      issue_entry(branch_word(f3, imm), k_cond, f3, imm, aligned_pc(), take_tag(),
                  SRC_WAIT, '0, 3'd5, SRC_WAIT, '0, 3'd6);
      repeat (3) @(negedge clk);
      drive_cdb(p, 3'd5, a);
      @(negedge clk);
      clear_cdb();
      repeat (2) @(negedge clk);
      drive_cdb((p + 1) % 3, 3'd6, b);
      @(negedge clk);
      clear_cdb();
      wait_drain("single branch wake-up");

      // jalr and branch share the rs1 producer
      pick_operands(a, b);
      r = rnd();
      imm = {{20{r[11]}}, r[11:0]};
      issue_entry(jalr_word(imm), k_jalr, beq, imm, aligned_pc(), take_tag(),
                  SRC_WAIT, '0, 3'd2, SRC_WAIT, '0, 3'd0);
      r = rnd();
      imm = {{19{r[12]}}, r[12:1], 1'b0};
      issue_entry(branch_word(f3, imm), k_cond, f3, imm, aligned_pc(), take_tag(),
                  SRC_WAIT, '0, 3'd2, SRC_WAIT, '0, 3'd7);
      repeat (2) @(negedge clk);
      drive_cdb(p, 3'd2, a);
      drive_cdb((p + 2) % 3, 3'd7, b);
      @(negedge clk);
      clear_cdb();
      wait_drain("two port wake-up");
    end

    // fill all eight slots, then wake them together
    for (i = 0; i < 8; i++) begin
      f3 = f3_of($unsigned($random(seed)) % 6);
      r = rnd();
      imm = {{19{r[12]}}, r[12:1], 1'b0};
      if (i % 2 == 0) begin
        issue_entry(branch_word(f3, imm), k_cond, f3, imm, aligned_pc(), 3'(i),
                    SRC_WAIT, '0, 3'd1, SRC_RF, rnd(), 3'd0);
      end else begin
        issue_entry(branch_word(f3, imm), k_cond, f3, imm, aligned_pc(), 3'(i),
                    SRC_ROB, rnd(), 3'd0, SRC_WAIT, '0, 3'd3);
      end
    end
    check("rs_full", 1'b1, rs_full);
    repeat (2) @(negedge clk);
    check("rs_full", 1'b1, rs_full);
    pick_operands(a, b);
    drive_cdb(0, 3'd1, a);
    drive_cdb(2, 3'd3, b);
    @(negedge clk);
    clear_cdb();
    n = 0;
    while (cdb_branch_valid !== 1'b1 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (cdb_branch_valid !== 1'b1) begin
      errors++;
      $display("timeout at %0t ns: no result after waking the full station", $time);
    end else begin
      for (i = 0; i < 8; i++) begin
        check("cdb_branch_valid", 1'b1, cdb_branch_valid);
        @(negedge clk);
      end
      check("cdb_branch_valid", 1'b0, cdb_branch_valid);
    end
    wait_drain("fill and drain");
    check("scoreboard entries", 0, pending_count());
    check("rs_full", 1'b0, rs_full);
    finish_run();
  end

endmodule

`default_nettype wire

//--- flist.f
rv32i_pkg.sv
ooo_pkg.sv
rs_issue_if.sv
br_exec_if.sv
branch_issue_decode.sv
branch_rs.sv
branch_exec.sv
branch_top.sv
tb_branch_top.sv

//--- Bender.yml
package:
  name: branch_unit

sources:
  - rv32i_pkg.sv
  - ooo_pkg.sv
  - rs_issue_if.sv
  - br_exec_if.sv
  - branch_issue_decode.sv
  - branch_rs.sv
  - branch_exec.sv
  - branch_top.sv
  - target: simulation
    files:
      - tb_branch_top.sv
